// ==== scan_defs.svh ====
// build constants for the scanner and its testbench where the read latency sets every read pipeline depth
`ifndef SCAN_DEFS_SVH
`define SCAN_DEFS_SVH

// bytes in one command area
`define SCAN_AREA_LEN 128

// cycles to wait for the store ready level
`define SCAN_TIMEOUT 100

// address widths of the cddb and the local buffer
`define CDDB_AW 13
`define BUF_AW 11

// cycles from read strobe to read data
`define RAM_RD_LAT 2

`endif

// ==== scan_pkg.sv ====
// scanner types where the value byte sits at the even area address and the code in the low nibble of the next byte
`default_nettype none

package scan_pkg;

	// low nibble of the control byte
	typedef enum logic [3:0] {
		code_request     = 4'h0,
		code_status_run  = 4'h2,
		code_status_copy = 4'h3,
		code_save        = 4'h4,
		code_reserved    = 4'hf
	} code_e;

	// board mode register, one hot
	typedef enum logic [2:0] {
		mode_down   = 3'b100,
		mode_config = 3'b010,
		mode_run    = 3'b001
	} mode_e;

	typedef struct packed {
		logic [7:0] value;
		logic [7:0] low;
	} entry_bytes_t;

	typedef struct packed {
		logic [7:0] value;
		logic [3:0] param;
		code_e      code;
	} entry_fields_t;

	// low byte is both payload and code carrier
	typedef union packed {
		entry_bytes_t  bytes;
		entry_fields_t fields;
	} entry_t;

	typedef enum logic [4:0] {
		st_idle, st_copy, st_copy_wait,
		st_next, st_rd_val, st_rd_low, st_rd_wait,
		st_chan_rd, st_chan_cap, st_status,
		st_up_val, st_up_low, st_up_end,
		st_st_wait_w, st_st_wr1, st_st_wr2, st_st_wait_r, st_st_vfy0, st_st_vfy1,
		st_fail
	} scan_state_e;

endpackage

`default_nettype wire

// ==== ram_port_if.sv ====
// one byte-wide RAM port with no grant and no wait so the requester owns all timing
`timescale 1ns/100ps
`default_nettype none
`include "scan_defs.svh"

interface ram_port_if #(
	parameter int ADDR_W = `BUF_AW
) ();

	logic              en;
	logic              wren;
	logic [ADDR_W-1:0] addr;
	logic [7:0]        wdata;
	logic [7:0]        rdata;

	// read is en with wren low, write is en with wren high
	modport requester (output en, output wren, output addr, output wdata, input rdata);
	modport memory (input en, input wren, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== byte_ram.sv ====
// byte RAM with fixed read latency and no reset so contents are undefined until written
`timescale 1ns/100ps
`default_nettype none
`include "scan_defs.svh"

module byte_ram #(
	parameter int ADDR_W = `BUF_AW
) (
	input  logic       clk,
	ram_port_if.memory i_port
);

	logic [7:0] mem [2**ADDR_W];
	logic [7:0] rd_pipe [`RAM_RD_LAT];

	always_ff @(posedge clk) begin
		if (i_port.en && i_port.wren) begin
			mem[i_port.addr] <= i_port.wdata;
		end
	end

	// array read then output register stages
	always_ff @(posedge clk) begin
		if (i_port.en && !i_port.wren) begin
			rd_pipe[0] <= mem[i_port.addr];
		end
		for (int i = 1; i < `RAM_RD_LAT; i++) begin
			rd_pipe[i] <= rd_pipe[i - 1];
		end
	end

	assign i_port.rdata = rd_pipe[`RAM_RD_LAT - 1];

endmodule

`default_nettype wire

// ==== cddb_arbiter.sv ====
// cddb sharing by the scanner busy level where refused host accesses are dropped and never queued
`timescale 1ns/100ps
`default_nettype none

module cddb_arbiter (
	input  logic          clk,
	input  logic          rst,
	input  logic          i_busy,
	ram_port_if.memory    scan_port,
	ram_port_if.memory    host_port,
	ram_port_if.requester ram_port,
	output logic          o_host_refused
);

	// ======================================
	// port select
	// ======================================

	always_comb begin
		if (i_busy) begin
			ram_port.en    = scan_port.en;
			ram_port.wren  = scan_port.wren;
			ram_port.addr  = scan_port.addr;
			ram_port.wdata = scan_port.wdata;
		end else begin
			ram_port.en    = host_port.en;
			ram_port.wren  = host_port.wren;
			ram_port.addr  = host_port.addr;
			ram_port.wdata = host_port.wdata;
		end
	end

	// both peers see the same read data
	assign scan_port.rdata = ram_port.rdata;
	assign host_port.rdata = ram_port.rdata;

	// host tries during a scan, host retries later
	always_ff @(posedge clk) begin
		if (rst) begin
			o_host_refused <= 1'b0;
		end else begin
			o_host_refused <= i_busy && host_port.en;
		end
	end

endmodule

`default_nettype wire

// ==== area_scanner.sv ====
// area scanner that ignores base address bit 9 and allows the store timeout for both verify bytes together
`timescale 1ns/100ps
`default_nettype none
`include "scan_defs.svh"

module area_scanner (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  logic [9:0]          i_base_addr,
	input  scan_pkg::mode_e     i_mode,
	input  logic [7:0]          i_chan_rdata,
	input  logic                i_store_rdy,
	input  logic                i_store_rd_dv,
	input  logic [7:0]          i_store_rdata,
	output logic                o_busy,
	output logic                o_done,
	output logic                o_error,
	ram_port_if.requester       cddb_port,
	ram_port_if.requester       buf_port,
	output logic                o_chan_wren,
	output logic                o_chan_rden,
	output logic [11:0]         o_chan_addr,
	output logic [7:0]          o_chan_wdata,
	output logic                o_cudb_wren,
	output logic [`CDDB_AW-1:0] o_cudb_addr,
	output logic [7:0]          o_cudb_wdata,
	output logic                o_store_wren,
	output logic                o_store_rden,
	output logic                o_store_wr_dv,
	output logic [15:0]         o_store_addr,
	output logic [7:0]          o_store_wdata
);

	localparam int n_entries = `SCAN_AREA_LEN / 2;
	localparam int cnt_w     = $clog2(`SCAN_AREA_LEN);
	localparam int idx_w     = $clog2(n_entries + 1);
	localparam int tmo_w     = $clog2(`SCAN_TIMEOUT);
	localparam int lat       = `RAM_RD_LAT;
	localparam int aw        = `CDDB_AW;

	scan_pkg::scan_state_e state;
	scan_pkg::entry_t      entry;
	logic [cnt_w-1:0]      copy_cnt;
	logic [idx_w-1:0]      entry_idx;
	logic [tmo_w-1:0]      tmo_cnt;
	logic                  tmo_done;
	logic [aw-1:0]         start_area;
	logic [aw-1:0]         ent_addr;
	logic                  up_sel;
	logic                  cddb_en;
	logic                  cddb_wren;
	logic [aw-1:0]         cddb_addr;
	logic [7:0]            cddb_wdata;
	logic                  cddb_rd;
	logic [lat-1:0]        copy_dly;
	logic [lat-1:0]        buf_dly;
	logic                  buf_wr;
	logic                  buf_rd;
	logic [`BUF_AW-1:0]    buf_waddr;
	logic [`BUF_AW-1:0]    buf_raddr;
	logic [3:0]            ones;
	logic [7:0]            chk_byte;
	logic [7:0]            status;

	// ======================================
	// decode and port drive
	// ======================================

	assign start_area = aw'({i_base_addr, 4'b0000});
	assign ones       = 4'($countones(entry.fields.value));
	assign chk_byte   = {ones, 4'b0000};
	assign tmo_done   = (tmo_cnt == tmo_w'(`SCAN_TIMEOUT - 1));

	// status byte written back over the control byte
	always_comb begin
		case (entry.fields.code)
			scan_pkg::code_status_copy: status = entry.bytes.low;
			scan_pkg::code_status_run:
				status = (i_mode == scan_pkg::mode_run) ? 8'hff : entry.bytes.low;
			default: status = 8'hff;
		endcase
	end

	assign cddb_rd         = cddb_en && !cddb_wren;
	assign cddb_port.en    = cddb_en;
	assign cddb_port.wren  = cddb_wren;
	assign cddb_port.addr  = cddb_addr;
	assign cddb_port.wdata = cddb_wdata;

	// copy writes and walk reads never overlap
	assign buf_wr         = copy_dly[lat-1];
	assign buf_rd         = (state == scan_pkg::st_rd_val) || (state == scan_pkg::st_rd_low);
	assign buf_port.en    = buf_wr || buf_rd;
	assign buf_port.wren  = buf_wr;
	assign buf_port.addr  = buf_wr ? buf_waddr : buf_raddr;
	assign buf_port.wdata = cddb_port.rdata;

	assign o_busy       = (state != scan_pkg::st_idle);
	assign o_cudb_addr  = ent_addr + aw'(up_sel);
	assign o_store_addr = 16'(ent_addr);

	// read strobes delayed to the data
	always_ff @(posedge clk) begin
		if (rst) begin
			copy_dly <= '0;
			buf_dly  <= '0;
		end else begin
			copy_dly <= {copy_dly[lat-2:0], cddb_rd};
			buf_dly  <= {buf_dly[lat-2:0], buf_rd};
		end
	end

	// value byte arrives first and ends up high
	always_ff @(posedge clk) begin
		if (buf_dly[lat-1]) begin
			entry <= {entry.bytes.low, buf_port.rdata};
		end
	end

	// ======================================
	// scan FSM
	// ======================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= scan_pkg::st_idle;
			cddb_en       <= 1'b0;
			cddb_wren     <= 1'b0;
			o_done        <= 1'b0;
			o_error       <= 1'b0;
			o_chan_wren   <= 1'b0;
			o_chan_rden   <= 1'b0;
			o_cudb_wren   <= 1'b0;
			o_store_wren  <= 1'b0;
			o_store_rden  <= 1'b0;
			o_store_wr_dv <= 1'b0;
			copy_cnt      <= '0;
			entry_idx     <= '0;
			tmo_cnt       <= '0;
			up_sel        <= 1'b0;
			buf_waddr     <= '0;
			buf_raddr     <= '0;
		end else begin
			o_done  <= 1'b0;
			o_error <= 1'b0;
			if (buf_wr) begin
				buf_waddr <= buf_waddr + 1'b1;
			end
			case (state)
				scan_pkg::st_idle: begin
					if (i_start) begin
						state       <= scan_pkg::st_copy;
						cddb_en     <= 1'b1;
						cddb_wren   <= 1'b0;
						cddb_addr   <= start_area;
						copy_cnt    <= '0;
						ent_addr    <= start_area;
						// board map puts area bit 12 on channel bit 10
						o_chan_addr <= {1'b0, start_area[aw-1], start_area[10:1]};
						buf_waddr   <= '0;
						buf_raddr   <= '0;
						entry_idx   <= '0;
					end
				end
				scan_pkg::st_copy: begin
					cddb_addr <= cddb_addr + 1'b1;
					copy_cnt  <= copy_cnt + 1'b1;
					if (copy_cnt == cnt_w'(`SCAN_AREA_LEN - 1)) begin
						cddb_en <= 1'b0;
						state   <= scan_pkg::st_copy_wait;
					end
				end
				scan_pkg::st_copy_wait: begin
					if (copy_dly == '0) begin
						state <= scan_pkg::st_next;
					end
				end
				scan_pkg::st_next: begin
					if (entry_idx == idx_w'(n_entries)) begin
						o_done <= 1'b1;
						state  <= scan_pkg::st_idle;
					end else begin
						state <= scan_pkg::st_rd_val;
					end
				end
				scan_pkg::st_rd_val: begin
					buf_raddr <= buf_raddr + 1'b1;
					state     <= scan_pkg::st_rd_low;
				end
				scan_pkg::st_rd_low: begin
					buf_raddr <= buf_raddr + 1'b1;
					state     <= scan_pkg::st_rd_wait;
				end
				scan_pkg::st_rd_wait: begin
					if (buf_dly == '0) begin
						if (entry.fields.code == scan_pkg::code_request) begin
							o_chan_rden <= 1'b1;
							state       <= scan_pkg::st_chan_rd;
						end else if (entry.fields.code == scan_pkg::code_save) begin
							tmo_cnt <= '0;
							state   <= scan_pkg::st_st_wait_w;
						end else begin
							o_chan_wren  <= 1'b1;
							o_chan_wdata <= entry.fields.value;
							state        <= scan_pkg::st_status;
						end
					end
				end
				scan_pkg::st_chan_rd: begin
					o_chan_rden <= 1'b0;
					state       <= scan_pkg::st_chan_cap;
				end
				scan_pkg::st_chan_cap: begin
					o_chan_addr  <= o_chan_addr + 1'b1;
					o_cudb_wren  <= 1'b1;
					o_cudb_wdata <= i_chan_rdata;
					state        <= scan_pkg::st_up_low;
				end
				scan_pkg::st_status: begin
					o_chan_wren <= 1'b0;
					o_chan_addr <= o_chan_addr + 1'b1;
					cddb_en     <= 1'b1;
					cddb_wren   <= 1'b1;
					cddb_addr   <= ent_addr + 1'b1;
					cddb_wdata  <= status;
					state       <= scan_pkg::st_up_val;
				end
				scan_pkg::st_up_val: begin
					cddb_en      <= 1'b0;
					cddb_wren    <= 1'b0;
					o_cudb_wren  <= 1'b1;
					o_cudb_wdata <= entry.fields.value;
					state        <= scan_pkg::st_up_low;
				end
				scan_pkg::st_up_low: begin
					up_sel       <= 1'b1;
					o_cudb_wdata <= entry.bytes.low;
					state        <= scan_pkg::st_up_end;
				end
				scan_pkg::st_up_end: begin
					o_cudb_wren <= 1'b0;
					up_sel      <= 1'b0;
					ent_addr    <= ent_addr + aw'(2);
					entry_idx   <= entry_idx + 1'b1;
					state       <= scan_pkg::st_next;
				end
				// store write of value and checksum
				scan_pkg::st_st_wait_w: begin
					if (i_store_rdy) begin
						o_store_wren  <= 1'b1;
						o_store_wr_dv <= 1'b1;
						o_store_wdata <= entry.fields.value;
						state         <= scan_pkg::st_st_wr1;
					end else if (tmo_done) begin
						state <= scan_pkg::st_fail;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				scan_pkg::st_st_wr1: begin
					o_store_wren  <= 1'b0;
					o_store_wdata <= chk_byte;
					state         <= scan_pkg::st_st_wr2;
				end
				scan_pkg::st_st_wr2: begin
					o_store_wr_dv <= 1'b0;
					tmo_cnt       <= '0;
					state         <= scan_pkg::st_st_wait_r;
				end
				scan_pkg::st_st_wait_r: begin
					if (i_store_rdy) begin
						o_store_rden <= 1'b1;
						tmo_cnt      <= '0;
						state        <= scan_pkg::st_st_vfy0;
					end else if (tmo_done) begin
						state <= scan_pkg::st_fail;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				// readback in write order
				scan_pkg::st_st_vfy0: begin
					o_store_rden <= 1'b0;
					if (i_store_rd_dv) begin
						if (i_store_rdata == entry.fields.value) begin
							state <= scan_pkg::st_st_vfy1;
						end else begin
							state <= scan_pkg::st_fail;
						end
					end else if (tmo_done) begin
						state <= scan_pkg::st_fail;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				scan_pkg::st_st_vfy1: begin
					if (i_store_rd_dv) begin
						if (i_store_rdata == chk_byte) begin
							o_chan_wren  <= 1'b1;
							o_chan_wdata <= entry.fields.value;
							state        <= scan_pkg::st_status;
						end else begin
							state <= scan_pkg::st_fail;
						end
					end else if (tmo_done) begin
						state <= scan_pkg::st_fail;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				scan_pkg::st_fail: begin
					o_error <= 1'b1;
					state   <= scan_pkg::st_idle;
				end
				default: state <= scan_pkg::st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== scan_io_top.sv ====
// scanner top level with the channel, upload RAM and store kept outside and host cddb access refused while busy
`timescale 1ns/100ps
`default_nettype none
`include "scan_defs.svh"

module scan_io_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  logic [9:0]          i_base_addr,
	input  scan_pkg::mode_e     i_mode,
	output logic                o_busy,
	output logic                o_done,
	output logic                o_error,
	// host side of the cddb
	input  logic                i_host_en,
	input  logic                i_host_wren,
	input  logic [`CDDB_AW-1:0] i_host_addr,
	input  logic [7:0]          i_host_wdata,
	output logic [7:0]          o_host_rdata,
	output logic                o_host_refused,
	// channel device
	output logic                o_chan_wren,
	output logic                o_chan_rden,
	output logic [11:0]         o_chan_addr,
	output logic [7:0]          o_chan_wdata,
	input  logic [7:0]          i_chan_rdata,
	// upload RAM
	output logic                o_cudb_wren,
	output logic [`CDDB_AW-1:0] o_cudb_addr,
	output logic [7:0]          o_cudb_wdata,
	// nonvolatile store
	output logic                o_store_wren,
	output logic                o_store_rden,
	output logic                o_store_wr_dv,
	output logic [15:0]         o_store_addr,
	output logic [7:0]          o_store_wdata,
	input  logic                i_store_rdy,
	input  logic                i_store_rd_dv,
	input  logic [7:0]          i_store_rdata
);

	ram_port_if #(.ADDR_W(`CDDB_AW)) scan_cddb ();
	ram_port_if #(.ADDR_W(`CDDB_AW)) host_cddb ();
	ram_port_if #(.ADDR_W(`CDDB_AW)) ram_cddb ();
	ram_port_if #(.ADDR_W(`BUF_AW))  buf_port ();

	// ======================================
	// host port wiring
	// ======================================

	assign host_cddb.en    = i_host_en;
	assign host_cddb.wren  = i_host_wren;
	assign host_cddb.addr  = i_host_addr;
	assign host_cddb.wdata = i_host_wdata;
	assign o_host_rdata    = host_cddb.rdata;

	byte_ram #(.ADDR_W(`CDDB_AW)) u_cddb (
		.clk    (clk),
		.i_port (ram_cddb)
	);

	// local copy of the area
	byte_ram #(.ADDR_W(`BUF_AW)) u_buf (
		.clk    (clk),
		.i_port (buf_port)
	);

	cddb_arbiter u_arb (
		.clk            (clk),
		.rst            (rst),
		.i_busy         (o_busy),
		.scan_port      (scan_cddb),
		.host_port      (host_cddb),
		.ram_port       (ram_cddb),
		.o_host_refused (o_host_refused)
	);

	area_scanner u_scan (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_base_addr   (i_base_addr),
		.i_mode        (i_mode),
		.i_chan_rdata  (i_chan_rdata),
		.i_store_rdy   (i_store_rdy),
		.i_store_rd_dv (i_store_rd_dv),
		.i_store_rdata (i_store_rdata),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_error       (o_error),
		.cddb_port     (scan_cddb),
		.buf_port      (buf_port),
		.o_chan_wren   (o_chan_wren),
		.o_chan_rden   (o_chan_rden),
		.o_chan_addr   (o_chan_addr),
		.o_chan_wdata  (o_chan_wdata),
		.o_cudb_wren   (o_cudb_wren),
		.o_cudb_addr   (o_cudb_addr),
		.o_cudb_wdata  (o_cudb_wdata),
		.o_store_wren  (o_store_wren),
		.o_store_rden  (o_store_rden),
		.o_store_wr_dv (o_store_wr_dv),
		.o_store_addr  (o_store_addr),
		.o_store_wdata (o_store_wdata)
	);

endmodule

`default_nettype wire

// ==== scan_io_checker.sv ====
// assertions on the scanner end pulses and strobes, sampled at the rising clock and off during reset
`timescale 1ns/100ps
`default_nettype none

module scan_io_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  i_busy,
	input logic                  i_done,
	input logic                  i_error,
	input logic                  i_store_wren,
	input logic                  i_store_wr_dv,
	input logic                  i_scan_en,
	input logic                  i_scan_wren,
	input scan_pkg::scan_state_e i_state
);

	// ======================================
	// end of scan
	// ======================================

	assert property (@(posedge clk) disable iff (rst) !(i_done && i_error))
		else $error("done and error pulsed together");

	assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
		else $error("done held longer than one cycle");

	assert property (@(posedge clk) disable iff (rst) i_error |=> !i_error)
		else $error("error held longer than one cycle");

	// busy falls together with the end pulse
	assert property (@(posedge clk) disable iff (rst)
		(i_done || i_error) |-> (i_state == scan_pkg::st_idle && $past(i_busy)))
		else $error("end pulse without busy falling in the same cycle");

	// ======================================
	// strobes
	// ======================================

	assert property (@(posedge clk) disable iff (rst) i_store_wren |-> i_store_wr_dv)
		else $error("store write strobe without write data valid");

	// outside a scan only the host may write the cddb
	assert property (@(posedge clk) disable iff (rst) !i_busy |-> !(i_scan_en && i_scan_wren))
		else $error("scanner cddb write while not busy");

endmodule

bind scan_io_top scan_io_checker u_chk (
	.clk           (clk),
	.rst           (rst),
	.i_busy        (o_busy),
	.i_done        (o_done),
	.i_error       (o_error),
	.i_store_wren  (o_store_wren),
	.i_store_wr_dv (o_store_wr_dv),
	.i_scan_en     (u_scan.cddb_en),
	.i_scan_wren   (u_scan.cddb_wren),
	.i_state       (u_scan.state)
);

`default_nettype wire

// ==== scan_io_tb.sv ====
// directed testbench with channel, upload RAM and store models, scan bases kept below 512 as the scanner ignores bit 9
`timescale 1ns/100ps
`default_nettype none
`include "scan_defs.svh"

module scan_io_tb;

	localparam int n_ent       = `SCAN_AREA_LEN / 2;
	localparam int scan_cycles = 2000;
	localparam int n_scans     = 7;
	// each scan gets its own budget including load and readback
	localparam int watchdog_ns = n_scans * scan_cycles * 20;

	logic                clk;
	logic                rst;
	logic                i_start;
	logic [9:0]          i_base_addr;
	scan_pkg::mode_e     i_mode;
	logic                o_busy;
	logic                o_done;
	logic                o_error;
	logic                i_host_en;
	logic                i_host_wren;
	logic [`CDDB_AW-1:0] i_host_addr;
	logic [7:0]          i_host_wdata;
	logic [7:0]          o_host_rdata;
	logic                o_host_refused;
	logic                o_chan_wren;
	logic                o_chan_rden;
	logic [11:0]         o_chan_addr;
	logic [7:0]          o_chan_wdata;
	logic [7:0]          i_chan_rdata;
	logic                o_cudb_wren;
	logic [`CDDB_AW-1:0] o_cudb_addr;
	logic [7:0]          o_cudb_wdata;
	logic                o_store_wren;
	logic                o_store_rden;
	logic                o_store_wr_dv;
	logic [15:0]         o_store_addr;
	logic [7:0]          o_store_wdata;
	logic                i_store_rdy;
	logic                i_store_rd_dv;
	logic [7:0]          i_store_rdata;

	logic [7:0]       chan_mem [4096];
	logic [7:0]       chan_wr [4096];
	logic [7:0]       cudb_mem [2**`CDDB_AW];
	logic [7:0]       store_mem [65536];
	scan_pkg::entry_t ents [$];
	logic             store_bad;
	int               seed;
	int               errors;
	int               checks;
	int               up_cnt;
	int               st_wr_cnt;

	scan_io_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

	// ======================================
	// device models
	// ======================================

	initial begin : device_models
		int          rd_step;
		logic [15:0] rd_addr;
		logic [15:0] wr_addr;
		rd_step = 0;
		rd_addr = '0;
		wr_addr = '0;
		up_cnt = 0;
		st_wr_cnt = 0;
		i_chan_rdata = '0;
		i_store_rd_dv = 1'b0;
		i_store_rdata = '0;
		forever begin
			@(negedge clk);
			i_store_rd_dv = 1'b0;
			if (o_chan_rden) begin
				i_chan_rdata = chan_mem[o_chan_addr];
			end
			if (o_chan_wren) begin
				chan_wr[o_chan_addr] = o_chan_wdata;
			end
			if (o_cudb_wren) begin
				cudb_mem[o_cudb_addr] = o_cudb_wdata;
				up_cnt++;
			end
			// wren marks the first of two bytes
			if (o_store_wr_dv) begin
				if (o_store_wren) begin
					wr_addr = o_store_addr;
					st_wr_cnt++;
				end
				store_mem[wr_addr] = o_store_wdata;
				wr_addr = wr_addr + 16'd1;
			end
			if (rd_step != 0) begin
				rd_step++;
			end
			if (o_store_rden) begin
				rd_step = 1;
				rd_addr = o_store_addr;
			end
			if (rd_step == 2) begin
				i_store_rd_dv = 1'b1;
				i_store_rdata = store_mem[rd_addr];
			end
			if (rd_step == 4) begin
				i_store_rd_dv = 1'b1;
				i_store_rdata = store_mem[rd_addr + 16'd1] ^ {7'b0000000, store_bad};
				rd_step = 0;
			end
		end
	end

	// ======================================
	// expected values
	// ======================================

	function automatic logic [`CDDB_AW-1:0] area_of(logic [9:0] base);
		return {base[8:0], 4'b0000};
	endfunction

	// area address halved, then area bit 12 moved down to channel bit 10
	function automatic logic [11:0] chan_of(logic [`CDDB_AW-1:0] area);
		logic [11:0] ch;
		ch = 12'(area >> 1);
		ch[11] = 1'b0;
		ch[10] = area[12];
		return ch;
	endfunction

	function automatic logic [7:0] checksum_of(logic [7:0] v);
		logic [3:0] n;
		n = 4'd0;
		for (int b = 0; b < 8; b++) begin
			n = n + {3'b000, v[0]};
			v = v >> 1;
		end
		return {n, 4'h0};
	endfunction

	// cddb control byte after the scan, request entries are left alone
	function automatic logic [7:0] status_of(scan_pkg::entry_t e, scan_pkg::mode_e m);
		if (e.fields.code == scan_pkg::code_request || e.fields.code == scan_pkg::code_status_copy)
			return e.bytes.low;
		if (e.fields.code == scan_pkg::code_status_run && m != scan_pkg::mode_run)
			return e.bytes.low;
		return 8'hff;
	endfunction

	task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_entry(string what, scan_pkg::entry_t got, scan_pkg::entry_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(string what, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_end(string what, bit exp_error, bit saw_done, bit saw_error);
		checks++;
		if (!saw_done && !saw_error) begin
			errors++;
			$display("%s: the scan never ended with a done or error pulse", what);
		end else if (saw_error != exp_error || saw_done == exp_error) begin
			errors++;
			$display("** Error at %0t ns: %s ended with done %0b error %0b", $time, what,
				saw_done, saw_error);
		end
	endtask

	// ======================================
	// host port and scan control
	// ======================================

	task automatic host_write(input logic [`CDDB_AW-1:0] addr, input logic [7:0] d);
		i_host_en = 1'b1;
		i_host_wren = 1'b1;
		i_host_addr = addr;
		i_host_wdata = d;
		@(negedge clk);
		i_host_en = 1'b0;
		i_host_wren = 1'b0;
	endtask

	task automatic host_read(input logic [`CDDB_AW-1:0] addr, output logic [7:0] d);
		i_host_en = 1'b1;
		i_host_wren = 1'b0;
		i_host_addr = addr;
		@(negedge clk);
		i_host_en = 1'b0;
		repeat (`RAM_RD_LAT - 1) @(negedge clk);
		d = o_host_rdata;
	endtask

	// kind 0 all request, 1 mixed, 2 mixed with a save every eighth entry
	task automatic build_area(input int kind, input int save_at);
		scan_pkg::entry_t e;
		ents.delete();
		for (int i = 0; i < n_ent; i++) begin
			e.bytes.value = 8'($random(seed));
			e.bytes.low = 8'($random(seed));
			if (kind == 0) begin
				e.fields.code = scan_pkg::code_request;
			end else if (e.fields.code inside {scan_pkg::code_save, scan_pkg::code_reserved}) begin
				e.fields.code = scan_pkg::code_status_run;
			end
			if ((kind == 2 && i % 8 == 3) || i == save_at) begin
				e.fields.code = scan_pkg::code_save;
			end
			ents.push_back(e);
		end
	endtask

	task automatic load_area(input logic [9:0] base);
		logic [`CDDB_AW-1:0] a;
		a = area_of(base);
		foreach (ents[i]) begin
			host_write(a, ents[i].bytes.value);
			host_write(a + 13'd1, ents[i].bytes.low);
			a = a + 13'd2;
		end
	endtask

	task automatic start_scan(input logic [9:0] base, input scan_pkg::mode_e mode);
		i_base_addr = base;
		i_mode = mode;
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		check_flag("busy one cycle after start", o_busy, 1'b1);
	endtask

	task automatic wait_end(output bit saw_done, output bit saw_error);
		saw_done = 1'b0;
		saw_error = 1'b0;
		for (int c = 0; c < scan_cycles; c++) begin
			@(negedge clk);
			if (o_done || o_error) begin
				saw_done = o_done;
				saw_error = o_error;
				break;
			end
		end
	endtask

	// uploads, channel writes, status bytes and store contents of a finished scan
	task automatic check_area(input logic [9:0] base, input scan_pkg::mode_e mode);
		logic [`CDDB_AW-1:0] a;
		logic [11:0]         ch;
		logic [7:0]          rd;
		scan_pkg::entry_t    exp;
		a = area_of(base);
		ch = chan_of(a);
		foreach (ents[i]) begin
			exp = ents[i];
			if (ents[i].fields.code == scan_pkg::code_request) begin
				exp.bytes.value = chan_mem[ch];
			end else begin
				check_byte("channel write", chan_wr[ch], ents[i].bytes.value);
			end
			check_entry("upload pair", {cudb_mem[a], cudb_mem[a + 13'd1]}, exp);
			host_read(a + 13'd1, rd);
			check_byte("cddb status", rd, status_of(ents[i], mode));
			if (ents[i].fields.code == scan_pkg::code_save) begin
				check_byte("store value", store_mem[16'(a)], ents[i].bytes.value);
				check_byte("store checksum", store_mem[16'(a) + 16'd1],
					checksum_of(ents[i].bytes.value));
			end
			a = a + 13'd2;
			ch = ch + 12'd1;
		end
	endtask

	// ======================================
	// directed tests
	// ======================================

	task automatic test_request_area();
		bit d;
		bit e;
		int n;
		build_area(0, -1);
		load_area(10'd2);
		n = up_cnt;
		start_scan(10'd2, scan_pkg::mode_run);
		wait_end(d, e);
		check_end("request area", 1'b0, d, e);
		check_count("upload writes", up_cnt - n, 2 * n_ent);
		check_area(10'd2, scan_pkg::mode_run);
	endtask

	task automatic test_status_modes();
		bit d;
		bit e;
		build_area(1, -1);
		load_area(10'd20);
		start_scan(10'd20, scan_pkg::mode_run);
		wait_end(d, e);
		check_end("mixed codes in run mode", 1'b0, d, e);
		check_area(10'd20, scan_pkg::mode_run);
		load_area(10'd40);
		start_scan(10'd40, scan_pkg::mode_config);
		wait_end(d, e);
		check_end("mixed codes in config mode", 1'b0, d, e);
		check_area(10'd40, scan_pkg::mode_config);
	endtask

	// base 300 puts area bit 12 on channel bit 10
	task automatic test_save_ok();
		bit d;
		bit e;
		build_area(2, -1);
		load_area(10'd300);
		start_scan(10'd300, scan_pkg::mode_config);
		wait_end(d, e);
		check_end("save entries", 1'b0, d, e);
		check_area(10'd300, scan_pkg::mode_config);
	endtask

	task automatic test_save_corrupt();
		bit d;
		bit e;
		int n;
		build_area(1, 5);
		load_area(10'd80);
		store_bad = 1'b1;
		n = up_cnt;
		start_scan(10'd80, scan_pkg::mode_run);
		wait_end(d, e);
		store_bad = 1'b0;
		check_end("corrupted store readback", 1'b1, d, e);
		check_count("uploads before the failing save", up_cnt - n, 10);
	endtask

	task automatic test_save_no_ready();
		bit d;
		bit e;
		int n;
		build_area(1, 7);
		load_area(10'd90);
		i_store_rdy = 1'b0;
		n = st_wr_cnt;
		start_scan(10'd90, scan_pkg::mode_run);
		wait_end(d, e);
		i_store_rdy = 1'b1;
		check_end("store never ready", 1'b1, d, e);
		check_count("store write strobes", st_wr_cnt - n, 0);
	endtask

	task automatic test_host_refused();
		logic [`CDDB_AW-1:0] a;
		logic [7:0]          rd;
		bit                  d;
		bit                  e;
		build_area(0, -1);
		load_area(10'd60);
		a = area_of(10'd60);
		start_scan(10'd60, scan_pkg::mode_run);
		host_write(a, ~ents[0].bytes.value);
		check_flag("host refused during scan", o_host_refused, 1'b1);
		wait_end(d, e);
		check_end("scan with host traffic", 1'b0, d, e);
		host_read(a, rd);
		check_byte("cddb after refused write", rd, ents[0].bytes.value);
		host_write(a, ~ents[0].bytes.value);
		check_flag("host refused while idle", o_host_refused, 1'b0);
		host_read(a, rd);
		check_byte("cddb after host write", rd, ~ents[0].bytes.value);
	endtask

	initial begin
		seed = 32'hf8f9;
		errors = 0;
		checks = 0;
		rst = 1'b1;
		i_start = 1'b0;
		i_base_addr = '0;
		i_mode = scan_pkg::mode_down;
		i_host_en = 1'b0;
		i_host_wren = 1'b0;
		i_host_addr = '0;
		i_host_wdata = '0;
		i_store_rdy = 1'b1;
		store_bad = 1'b0;
		// pattern covers all twelve address bits
		for (int a = 0; a < 4096; a++) begin
			chan_mem[12'(a)] = 8'(a) ^ 8'(a >> 4);
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag("outputs low after reset", o_busy | o_done | o_error | o_host_refused |
			o_chan_wren | o_chan_rden | o_cudb_wren | o_store_wren | o_store_rden |
			o_store_wr_dv, 1'b0);
		test_request_area();
		test_status_modes();
		test_save_ok();
		test_save_corrupt();
		test_save_no_ready();
		test_host_refused();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
scan_pkg.sv
ram_port_if.sv
byte_ram.sv
cddb_arbiter.sv
area_scanner.sv
scan_io_top.sv
scan_io_checker.sv
scan_io_tb.sv

// ==== Makefile ====
# Verilator build and run of the scanner testbench, from the project root

TOP := scan_io_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
